// File: soc_pkg.sv
package soc_pkg;

    // access type carried on bus_read_type and bus_write_type
    typedef logic [2:0] access_t;

    // load codes
    localparam access_t LD_B  = 3'b000;
    localparam access_t LD_H  = 3'b001;
    localparam access_t LD_W  = 3'b010;
    localparam access_t LD_D  = 3'b011;
    localparam access_t LD_BU = 3'b100;
    localparam access_t LD_HU = 3'b101;
    localparam access_t LD_WU = 3'b110;

    // store codes
    localparam access_t ST_B = 3'b000;
    localparam access_t ST_H = 3'b001;
    localparam access_t ST_W = 3'b010;
    localparam access_t ST_D = 3'b011;

    // data RAM window starts here, size comes from RAM_WORDS
    localparam logic [63:0] RAM_BASE = 64'h0000_0000_0000_0000;

    // single-register peripherals
    localparam logic [63:0] KEY_ADDR     = 64'h0000_0000_0000_f000;
    localparam logic [63:0] UART_ADDR    = 64'h0000_0000_0000_f008;
    localparam logic [63:0] SD_ADDR_REG  = 64'h0000_0000_0000_f010;
    localparam logic [63:0] SD_READ_REG  = 64'h0000_0000_0000_f018;
    localparam logic [63:0] SD_READY_REG = 64'h0000_0000_0000_f020;
    localparam logic [63:0] SD_AVAIL_REG = 64'h0000_0000_0000_f028;

    // sector buffer window, one byte per address
    localparam logic [63:0] SD_BUF_BASE  = 64'h0000_0000_0000_e000;
    localparam int          SD_BUF_BYTES = 512;

    // vector value raised for a key event
    localparam logic [3:0] IRQ_KEY = 4'd1;

endpackage

// File: data_ram.sv
`timescale 1ns/10ps

module data_ram #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    input  logic [3:0]                   ram_wstrb,
    input  logic [31:0]                  ram_wdata,
    output logic [31:0]                  ram_rdata
);

    // one 32-bit word per entry, lane 0 is the lowest address byte
    logic [31:0] mem [RAM_WORDS];

    // byte lanes written independently
    always_ff @(posedge CLOCK_50) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (ram_wstrb[lane]) begin
                mem[ram_addr][8*lane +: 8] <= ram_wdata[8*lane +: 8];
            end
        end
    end

    // registered read port, old data on a same-cycle write
    always_ff @(posedge CLOCK_50) begin
        ram_rdata <= mem[ram_addr];
    end

endmodule

// File: key_irq_ctrl.sv
`timescale 1ns/10ps

module key_irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       key_valid,
    input  logic [7:0] key_ascii,
    input  logic       interrupt_ack,
    output logic [7:0] key_ascii_q,
    output logic [3:0] interrupt_vector
);

    logic key_event;

    // only printable events interrupt, a zero code is stored silently
    assign key_event = key_valid && (key_ascii != 8'd0);

    // last character seen, read back through KEY_ADDR
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_ascii_q <= 8'd0;
        end else if (key_valid) begin
            key_ascii_q <= key_ascii;
        end
    end

    // level interrupt held until the core acknowledges
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            interrupt_vector <= 4'd0;
        end else if (key_event) begin
            // a new key beats a same-cycle ack
            interrupt_vector <= soc_pkg::IRQ_KEY;
        end else if (interrupt_ack && (interrupt_vector != 4'd0)) begin
            interrupt_vector <= 4'd0;
        end
    end

endmodule

// File: sd_sector_buffer.sv
`timescale 1ns/10ps

module sd_sector_buffer (
    input  logic        CLOCK_50,
    input  logic        KEY0,
    input  logic        sd_addr_wr,
    input  logic        sd_read_wr,
    input  logic [31:0] sd_wdata,
    input  logic [8:0]  sd_buf_index,
    output logic [7:0]  sd_buf_byte,
    output logic        sd_avail,
    output logic        sd_rd_start,
    output logic [31:0] sd_addr,
    input  logic        sd_byte_available,
    input  logic [7:0]  sd_byte
);

    logic [7:0] sector_mem [soc_pkg::SD_BUF_BYTES];
    logic [8:0] byte_idx;
    logic       strobe_q;
    logic       capture;

    // one byte per rising edge of the controller strobe
    assign capture = sd_byte_available && !strobe_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= sd_byte_available;
        end
    end

    // sector address and read start pulse
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            sd_addr     <= 32'd0;
            sd_rd_start <= 1'b0;
        end else begin
            sd_rd_start <= sd_read_wr;
            if (sd_addr_wr) begin
                sd_addr <= sd_wdata;
            end
        end
    end

    // index wraps to zero after the last byte of the sector
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            byte_idx <= 9'd0;
            sd_avail <= 1'b0;
        end else begin
            if (capture) begin
                byte_idx <= byte_idx + 9'd1;
            end
            if (sd_rd_start) begin
                sd_avail <= 1'b0;
            end else if (capture && byte_idx == 9'(soc_pkg::SD_BUF_BYTES - 1)) begin
                sd_avail <= 1'b1;
            end
        end
    end

    // capture storage with a registered read port
    always_ff @(posedge CLOCK_50) begin
        if (capture) begin
            sector_mem[byte_idx] <= sd_byte;
        end
        sd_buf_byte <= sector_mem[sd_buf_index];
    end

endmodule

// File: soc_bus_bridge.sv
`timescale 1ns/10ps

module soc_bus_bridge #(
    parameter int RAM_WORDS = 1024
) (
    input  logic                         CLOCK_50,
    input  logic                         KEY0,
    input  logic [63:0]                  bus_address,
    input  logic                         bus_read_enable,
    input  soc_pkg::access_t             bus_read_type,
    input  logic                         bus_write_enable,
    input  soc_pkg::access_t             bus_write_type,
    input  logic [63:0]                  bus_write_data,
    output logic [63:0]                  bus_read_data,
    output logic                         bus_read_done,
    output logic                         bus_write_done,
    output logic [$clog2(RAM_WORDS)-1:0] ram_addr,
    output logic [3:0]                   ram_wstrb,
    output logic [31:0]                  ram_wdata,
    input  logic [31:0]                  ram_rdata,
    input  logic [7:0]                   key_ascii_q,
    output logic                         uart_valid,
    output logic [7:0]                   uart_data,
    input  logic                         uart_ready,
    output logic                         sd_addr_wr,
    output logic                         sd_read_wr,
    output logic [31:0]                  sd_wdata,
    input  logic                         sd_ready,
    input  logic                         sd_avail,
    output logic [8:0]                   sd_buf_index,
    input  logic [7:0]                   sd_buf_byte
);

    localparam int          AW      = $clog2(RAM_WORDS);
    localparam logic [63:0] RAM_END = soc_pkg::RAM_BASE + 64'(4 * RAM_WORDS);
    localparam logic [63:0] BUF_END = soc_pkg::SD_BUF_BASE + 64'(soc_pkg::SD_BUF_BYTES);

    typedef enum logic [2:0] {
        S_IDLE, S_RD_WAIT, S_RD_HI, S_WR_HI, S_WR_END, S_UART_WAIT
    } state_t;

    typedef enum logic [3:0] {
        T_NONE, T_RAM, T_KEY, T_UART, T_SD_ADDR, T_SD_READ,
        T_SD_READY, T_SD_AVAIL, T_SD_BUF
    } target_t;

    state_t           state;
    target_t          tgt;
    target_t          tgt_q;
    soc_pkg::access_t type_q;
    logic [1:0]       off_q;
    logic             wr_go;

    // sign or zero extend the addressed bytes of a RAM word
    function automatic logic [63:0] load_extend(input logic [31:0] word,
                                                input soc_pkg::access_t typ,
                                                input logic [1:0] off);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (typ)
            soc_pkg::LD_B:  load_extend = {{56{sh[7]}}, sh[7:0]};
            soc_pkg::LD_H:  load_extend = {{48{sh[15]}}, sh[15:0]};
            soc_pkg::LD_W:  load_extend = {{32{sh[31]}}, sh};
            soc_pkg::LD_BU: load_extend = {56'd0, sh[7:0]};
            soc_pkg::LD_HU: load_extend = {48'd0, sh[15:0]};
            default:        load_extend = {32'd0, sh};
        endcase
    endfunction

    // address decode, RAM first since it is the widest window
    always_comb begin
        tgt = T_NONE;
        if (bus_address >= soc_pkg::RAM_BASE && bus_address < RAM_END) begin
            tgt = T_RAM;
        end else if (bus_address >= soc_pkg::SD_BUF_BASE && bus_address < BUF_END) begin
            tgt = T_SD_BUF;
        end else if (bus_address == soc_pkg::KEY_ADDR) begin
            tgt = T_KEY;
        end else if (bus_address == soc_pkg::UART_ADDR) begin
            tgt = T_UART;
        end else if (bus_address == soc_pkg::SD_ADDR_REG) begin
            tgt = T_SD_ADDR;
        end else if (bus_address == soc_pkg::SD_READ_REG) begin
            tgt = T_SD_READ;
        end else if (bus_address == soc_pkg::SD_READY_REG) begin
            tgt = T_SD_READY;
        end else if (bus_address == soc_pkg::SD_AVAIL_REG) begin
            tgt = T_SD_AVAIL;
        end
    end

    assign wr_go = (state == S_IDLE) && bus_write_enable;

    // address is held by the core, so the second word is simply the next one
    assign ram_addr = bus_address[AW+1:2] + AW'(state != S_IDLE);

    // store steering onto byte lanes
    always_comb begin
        ram_wstrb = 4'b0000;
        ram_wdata = bus_write_data[31:0];
        if (wr_go && tgt == T_RAM) begin
            case (bus_write_type)
                soc_pkg::ST_B: begin
                    ram_wstrb = 4'b0001 << bus_address[1:0];
                    ram_wdata = {4{bus_write_data[7:0]}};
                end
                soc_pkg::ST_H: begin
                    ram_wstrb = 4'b0011 << {bus_address[1], 1'b0};
                    ram_wdata = {2{bus_write_data[15:0]}};
                end
                default: ram_wstrb = 4'b1111;
            endcase
        end else if (state == S_WR_HI) begin
            // upper half of sd
            ram_wstrb = 4'b1111;
            ram_wdata = bus_write_data[63:32];
        end
    end

    // sd buffer and register strobes, registered inside the buffer
    assign sd_addr_wr   = wr_go && (tgt == T_SD_ADDR);
    assign sd_read_wr   = wr_go && (tgt == T_SD_READ);
    assign sd_wdata     = bus_write_data[31:0];
    assign sd_buf_index = 9'(bus_address - soc_pkg::SD_BUF_BASE);

    // access sequencer and done flags
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= S_IDLE;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            uart_valid     <= 1'b0;
            tgt_q          <= T_NONE;
            type_q         <= soc_pkg::LD_B;
            off_q          <= 2'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (bus_read_enable) begin
                        bus_read_done <= 1'b0;
                        tgt_q         <= tgt;
                        type_q        <= bus_read_type;
                        off_q         <= bus_address[1:0];
                        state         <= S_RD_WAIT;
                    end else if (bus_write_enable) begin
                        bus_write_done <= 1'b0;
                        if (tgt == T_UART) begin
                            uart_valid <= 1'b1;
                            state      <= S_UART_WAIT;
                        end else if (tgt == T_RAM && bus_write_type == soc_pkg::ST_D) begin
                            state <= S_WR_HI;
                        end else begin
                            // narrow stores land on this edge, unmapped ones are dropped
                            state <= S_WR_END;
                        end
                    end
                end
                S_RD_WAIT: begin
                    if (tgt_q == T_RAM && type_q == soc_pkg::LD_D) begin
                        state <= S_RD_HI;
                    end else begin
                        bus_read_done <= 1'b1;
                        state         <= S_IDLE;
                    end
                end
                S_RD_HI: begin
                    bus_read_done <= 1'b1;
                    state         <= S_IDLE;
                end
                S_WR_HI: begin
                    state <= S_WR_END;
                end
                S_WR_END: begin
                    bus_write_done <= 1'b1;
                    state          <= S_IDLE;
                end
                S_UART_WAIT: begin
                    // done follows the handshake, however long the sink stalls
                    if (uart_ready) begin
                        uart_valid     <= 1'b0;
                        bus_write_done <= 1'b1;
                        state          <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // uart byte held until accepted
    always_ff @(posedge CLOCK_50) begin
        if (wr_go && tgt == T_UART) begin
            uart_data <= bus_write_data[7:0];
        end
    end

    // read data mux, RAM and buffer data arrive one cycle after the address
    always_ff @(posedge CLOCK_50) begin
        if (state == S_RD_WAIT) begin
            case (tgt_q)
                T_RAM: begin
                    if (type_q == soc_pkg::LD_D) begin
                        bus_read_data[31:0] <= ram_rdata;
                    end else begin
                        bus_read_data <= load_extend(ram_rdata, type_q, off_q);
                    end
                end
                T_KEY:      bus_read_data <= {56'd0, key_ascii_q};
                T_SD_READY: bus_read_data <= {63'd0, sd_ready};
                T_SD_AVAIL: bus_read_data <= {63'd0, sd_avail};
                T_SD_BUF:   bus_read_data <= {56'd0, sd_buf_byte};
                // unmapped or write-only
                default:    bus_read_data <= 64'd0;
            endcase
        end else if (state == S_RD_HI) begin
            bus_read_data[63:32] <= ram_rdata;
        end
    end

endmodule

// File: soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top #(
    parameter int RAM_WORDS = 1024
) (
    input  logic             CLOCK_50,
    input  logic             KEY0,
    input  logic [63:0]      bus_address,
    input  logic             bus_read_enable,
    input  soc_pkg::access_t bus_read_type,
    input  logic             bus_write_enable,
    input  soc_pkg::access_t bus_write_type,
    input  logic [63:0]      bus_write_data,
    output logic [63:0]      bus_read_data,
    output logic             bus_read_done,
    output logic             bus_write_done,
    input  logic             key_valid,
    input  logic [7:0]       key_ascii,
    output logic [3:0]       interrupt_vector,
    input  logic             interrupt_ack,
    output logic             uart_valid,
    output logic [7:0]       uart_data,
    input  logic             uart_ready,
    output logic             sd_rd_start,
    output logic [31:0]      sd_addr,
    input  logic             sd_ready,
    input  logic             sd_byte_available,
    input  logic [7:0]       sd_byte
);

    logic [$clog2(RAM_WORDS)-1:0] ram_addr;
    logic [3:0]                   ram_wstrb;
    logic [31:0]                  ram_wdata;
    logic [31:0]                  ram_rdata;
    logic [7:0]                   key_ascii_q;
    logic                         sd_addr_wr;
    logic                         sd_read_wr;
    logic [31:0]                  sd_wdata;
    logic                         sd_avail;
    logic [8:0]                   sd_buf_index;
    logic [7:0]                   sd_buf_byte;

    soc_bus_bridge #(
        .RAM_WORDS(RAM_WORDS)
    ) i_bridge (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .bus_address(bus_address),
        .bus_read_enable(bus_read_enable),
        .bus_read_type(bus_read_type),
        .bus_write_enable(bus_write_enable),
        .bus_write_type(bus_write_type),
        .bus_write_data(bus_write_data),
        .bus_read_data(bus_read_data),
        .bus_read_done(bus_read_done),
        .bus_write_done(bus_write_done),
        .ram_addr(ram_addr),
        .ram_wstrb(ram_wstrb),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata),
        .key_ascii_q(key_ascii_q),
        .uart_valid(uart_valid),
        .uart_data(uart_data),
        .uart_ready(uart_ready),
        .sd_addr_wr(sd_addr_wr),
        .sd_read_wr(sd_read_wr),
        .sd_wdata(sd_wdata),
        .sd_ready(sd_ready),
        .sd_avail(sd_avail),
        .sd_buf_index(sd_buf_index),
        .sd_buf_byte(sd_buf_byte)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) i_ram (
        .CLOCK_50(CLOCK_50),
        .ram_addr(ram_addr),
        .ram_wstrb(ram_wstrb),
        .ram_wdata(ram_wdata),
        .ram_rdata(ram_rdata)
    );

    key_irq_ctrl i_key (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .key_valid(key_valid),
        .key_ascii(key_ascii),
        .interrupt_ack(interrupt_ack),
        .key_ascii_q(key_ascii_q),
        .interrupt_vector(interrupt_vector)
    );

    sd_sector_buffer i_sd (
        .CLOCK_50(CLOCK_50),
        .KEY0(KEY0),
        .sd_addr_wr(sd_addr_wr),
        .sd_read_wr(sd_read_wr),
        .sd_wdata(sd_wdata),
        .sd_buf_index(sd_buf_index),
        .sd_buf_byte(sd_buf_byte),
        .sd_avail(sd_avail),
        .sd_rd_start(sd_rd_start),
        .sd_addr(sd_addr),
        .sd_byte_available(sd_byte_available),
        .sd_byte(sd_byte)
    );

endmodule

// File: soc_bus_assertions.sv
`timescale 1ns/10ps

module soc_bus_assertions (
    input logic       CLOCK_50,
    input logic       KEY0,
    input logic       bus_read_enable,
    input logic       bus_write_enable,
    input logic       bus_read_done,
    input logic       bus_write_done,
    input logic       uart_valid,
    input logic       uart_ready,
    input logic [7:0] uart_data,
    input logic       sd_rd_start
);

    // reset values hold on the cycle after any reset edge
    reset_state: assert property (@(posedge CLOCK_50)
        !KEY0 |=> (bus_read_done && bus_write_done && !uart_valid))
        else $error("done flags or uart_valid wrong after reset");

    read_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable && bus_read_done) |=> !bus_read_done)
        else $error("bus_read_done did not fall after read enable");

    write_busy: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_write_enable && bus_write_done) |=> !bus_write_done)
        else $error("bus_write_done did not fall after write enable");

    // byte and valid held under back-pressure
    uart_hold: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (uart_valid && !uart_ready) |=> (uart_valid && $stable(uart_data)))
        else $error("uart byte changed before acceptance");

    start_pulse: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        sd_rd_start |=> !sd_rd_start)
        else $error("sd_rd_start longer than one cycle");

endmodule

bind soc_bus_top soc_bus_assertions i_assertions (
    .CLOCK_50(CLOCK_50),
    .KEY0(KEY0),
    .bus_read_enable(bus_read_enable),
    .bus_write_enable(bus_write_enable),
    .bus_read_done(bus_read_done),
    .bus_write_done(bus_write_done),
    .uart_valid(uart_valid),
    .uart_ready(uart_ready),
    .uart_data(uart_data),
    .sd_rd_start(sd_rd_start)
);

// File: tb_soc_bus.sv
`timescale 1ns/10ps

module tb_soc_bus;

    localparam int RAM_WORDS   = 1024;
    localparam int NUM_ENTRIES = 24;
    localparam int UART_CHARS  = 6;

    typedef struct packed {
        logic             wr;
        soc_pkg::access_t typ;
        logic [63:0]      addr;
        logic [63:0]      wdata;
        logic [63:0]      exp;
    } entry_t;

    logic             CLOCK_50;
    logic             KEY0;
    logic [63:0]      bus_address;
    logic             bus_read_enable;
    soc_pkg::access_t bus_read_type;
    logic             bus_write_enable;
    soc_pkg::access_t bus_write_type;
    logic [63:0]      bus_write_data;
    logic [63:0]      bus_read_data;
    logic             bus_read_done;
    logic             bus_write_done;
    logic             key_valid;
    logic [7:0]       key_ascii;
    logic [3:0]       interrupt_vector;
    logic             interrupt_ack;
    logic             uart_valid;
    logic [7:0]       uart_data;
    logic             uart_ready;
    logic             sd_rd_start;
    logic [31:0]      sd_addr;
    logic             sd_ready;
    logic             sd_byte_available;
    logic [7:0]       sd_byte;

    int         errors       = 0;
    int         tests_run    = 0;
    int         tests_failed = 0;
    int         start_count  = 0;
    logic [7:0] sector [512];
    logic [7:0] uart_sent [UART_CHARS];
    logic [7:0] uart_got [$];

    // word 0x80f1_7f02 at 0x100 holds bytes 02 7f f1 80, lowest address first
    entry_t tbl [NUM_ENTRIES] = '{
        '{1'b1, soc_pkg::ST_W,  64'h100, 64'h80f1_7f02, 64'h0},
        '{1'b0, soc_pkg::LD_B,  64'h100, 64'h0, 64'h02},
        '{1'b0, soc_pkg::LD_B,  64'h102, 64'h0, 64'hffff_ffff_ffff_fff1},
        '{1'b0, soc_pkg::LD_BU, 64'h102, 64'h0, 64'hf1},
        '{1'b0, soc_pkg::LD_B,  64'h101, 64'h0, 64'h7f},
        '{1'b0, soc_pkg::LD_BU, 64'h103, 64'h0, 64'h80},
        '{1'b0, soc_pkg::LD_H,  64'h100, 64'h0, 64'h7f02},
        '{1'b0, soc_pkg::LD_H,  64'h102, 64'h0, 64'hffff_ffff_ffff_80f1},
        '{1'b0, soc_pkg::LD_HU, 64'h102, 64'h0, 64'h80f1},
        '{1'b0, soc_pkg::LD_W,  64'h100, 64'h0, 64'hffff_ffff_80f1_7f02},
        '{1'b0, soc_pkg::LD_WU, 64'h100, 64'h0, 64'h80f1_7f02},
        // upper store bits must be ignored
        '{1'b1, soc_pkg::ST_B,  64'h101, 64'h1234_55aa, 64'h0},
        '{1'b0, soc_pkg::LD_WU, 64'h100, 64'h0, 64'h80f1_aa02},
        '{1'b1, soc_pkg::ST_H,  64'h102, 64'hffff_1234, 64'h0},
        '{1'b0, soc_pkg::LD_WU, 64'h100, 64'h0, 64'h1234_aa02},
        '{1'b0, soc_pkg::LD_H,  64'h102, 64'h0, 64'h1234},
        '{1'b1, soc_pkg::ST_D,  64'h200, 64'h0123_4567_89ab_cdef, 64'h0},
        '{1'b0, soc_pkg::LD_D,  64'h200, 64'h0, 64'h0123_4567_89ab_cdef},
        '{1'b0, soc_pkg::LD_W,  64'h200, 64'h0, 64'hffff_ffff_89ab_cdef},
        '{1'b0, soc_pkg::LD_WU, 64'h204, 64'h0, 64'h0123_4567},
        // 0x8000 is unmapped but its low bits alias word 0
        '{1'b1, soc_pkg::ST_W,  64'h0,    64'h1111_2222, 64'h0},
        '{1'b1, soc_pkg::ST_W,  64'h8000, 64'hdead_beef, 64'h0},
        '{1'b0, soc_pkg::LD_WU, 64'h0,    64'h0, 64'h1111_2222},
        '{1'b0, soc_pkg::LD_D,  64'h8000, 64'h0, 64'h0}
    };

    soc_bus_top #(.RAM_WORDS(RAM_WORDS)) i_dut (.*);

    initial begin : clock_gen
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    // table accesses plus one sector with margin
    initial begin : watchdog
        repeat (NUM_ENTRIES * 20 + 600 * 8) @(posedge CLOCK_50);
        $display("watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    // uart receiver, stalls 0 to 7 cycles before taking each byte
    initial begin : uart_sink
        int stall;
        uart_ready = 1'b0;
        forever begin
            @(negedge CLOCK_50);
            if (uart_valid === 1'b1) begin
                stall = $urandom_range(7, 0);
                repeat (stall + 1) @(posedge CLOCK_50);
                uart_ready <= 1'b1;
                @(negedge CLOCK_50);
                uart_got.push_back(uart_data);
                @(posedge CLOCK_50);
                uart_ready <= 1'b0;
            end
        end
    end

    always @(negedge CLOCK_50) begin
        if (sd_rd_start === 1'b1) begin
            start_count <= start_count + 1;
        end
    end

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // one core access, low counts the cycles done stayed low
    task automatic bus_access(input logic wr, input soc_pkg::access_t typ,
                              input logic [63:0] addr, input logic [63:0] wdata,
                              output logic [63:0] rdata, output int low);
        low = 0;
        @(posedge CLOCK_50);
        bus_address      <= addr;
        bus_read_type    <= typ;
        bus_write_type   <= typ;
        bus_write_data   <= wdata;
        bus_read_enable  <= !wr;
        bus_write_enable <= wr;
        @(posedge CLOCK_50);
        bus_read_enable  <= 1'b0;
        bus_write_enable <= 1'b0;
        @(negedge CLOCK_50);
        while (!(wr ? bus_write_done : bus_read_done) && low < 40) begin
            low++;
            @(negedge CLOCK_50);
        end
        if (low == 40) begin
            $display("bus access at %h never completed", addr);
            errors++;
        end
        rdata = bus_read_data;
    endtask

    task automatic key_cycle(input logic valid, input logic [7:0] ascii, input logic ack);
        @(posedge CLOCK_50);
        key_valid     <= valid;
        key_ascii     <= ascii;
        interrupt_ack <= ack;
        @(posedge CLOCK_50);
        key_valid     <= 1'b0;
        interrupt_ack <= 1'b0;
        @(negedge CLOCK_50);
    endtask

    // one byte every two cycles, strobe low in between
    task automatic stream_sector();
        for (int i = 0; i < 512; i++) begin
            sector[i] = 8'($urandom);
            @(posedge CLOCK_50);
            sd_byte           <= sector[i];
            sd_byte_available <= 1'b1;
            @(posedge CLOCK_50);
            sd_byte_available <= 1'b0;
        end
        repeat (2) @(posedge CLOCK_50);
    endtask

    initial begin : main
        logic [63:0] rdata;
        int          low;
        int          errs0;
        int          starts0;
        void'($urandom(32'h9965_6e0f));
        KEY0              = 1'b0;
        bus_address       = 64'd0;
        bus_read_enable   = 1'b0;
        bus_read_type     = soc_pkg::LD_B;
        bus_write_enable  = 1'b0;
        bus_write_type    = soc_pkg::ST_B;
        bus_write_data    = 64'd0;
        key_valid         = 1'b0;
        key_ascii         = 8'd0;
        interrupt_ack     = 1'b0;
        sd_ready          = 1'b0;
        sd_byte_available = 1'b0;
        sd_byte           = 8'd0;
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            errs0 = errors;
            bus_access(tbl[i].wr, tbl[i].typ, tbl[i].addr, tbl[i].wdata, rdata, low);
            if (!tbl[i].wr) begin
                compare_value($sformatf("entry %0d read data", i), rdata, tbl[i].exp);
            end
            // 64-bit RAM accesses take one extra cycle
            compare_value($sformatf("entry %0d busy cycles", i), 64'(low),
                (tbl[i].typ == 3'b011 && tbl[i].addr < 64'(4 * RAM_WORDS)) ? 64'd2 : 64'd1);
            report_test($sformatf("table entry %0d", i), errs0);
        end

        errs0 = errors;
        key_cycle(1'b1, 8'h41, 1'b0);
        compare_value("vector after key", 64'(interrupt_vector), 64'd1);
        // key and ack together, the key wins
        key_cycle(1'b1, 8'hc2, 1'b1);
        compare_value("vector after key with ack", 64'(interrupt_vector), 64'd1);
        bus_access(1'b0, soc_pkg::LD_D, soc_pkg::KEY_ADDR, 64'd0, rdata, low);
        compare_value("key register", rdata, 64'hc2);
        key_cycle(1'b0, 8'h00, 1'b1);
        compare_value("vector after ack", 64'(interrupt_vector), 64'd0);
        key_cycle(1'b1, 8'h00, 1'b0);
        compare_value("vector after zero key", 64'(interrupt_vector), 64'd0);
        report_test("keyboard interrupt", errs0);

        errs0 = errors;
        for (int k = 0; k < UART_CHARS; k++) begin
            uart_sent[k] = 8'($urandom);
            bus_access(1'b1, soc_pkg::ST_W, soc_pkg::UART_ADDR,
                       {56'h5a5a_c3f0_0f3c_a5, uart_sent[k]}, rdata, low);
            compare_value($sformatf("bytes accepted at write %0d", k),
                          64'(uart_got.size()), 64'(k + 1));
        end
        for (int k = 0; k < uart_got.size() && k < UART_CHARS; k++) begin
            compare_value($sformatf("uart byte %0d", k), 64'(uart_got[k]), 64'(uart_sent[k]));
        end
        report_test("uart output", errs0);

        errs0 = errors;
        bus_access(1'b1, soc_pkg::ST_W, soc_pkg::SD_ADDR_REG, 64'hffff_ffff_0001_2345, rdata, low);
        compare_value("sd_addr", 64'(sd_addr), 64'h0001_2345);
        starts0 = start_count;
        bus_access(1'b1, soc_pkg::ST_W, soc_pkg::SD_READ_REG, 64'd1, rdata, low);
        compare_value("read start pulses", 64'(start_count - starts0), 64'd1);
        stream_sector();
        bus_access(1'b0, soc_pkg::LD_D, soc_pkg::SD_AVAIL_REG, 64'd0, rdata, low);
        compare_value("available after 512 bytes", rdata, 64'd1);
        for (int n = 0; n < 512; n++) begin
            bus_access(1'b0, soc_pkg::LD_BU, soc_pkg::SD_BUF_BASE + 64'(n), 64'd0, rdata, low);
            compare_value($sformatf("buffer byte %0d", n), rdata, 64'(sector[n]));
        end
        bus_access(1'b1, soc_pkg::ST_W, soc_pkg::SD_READ_REG, 64'd1, rdata, low);
        bus_access(1'b0, soc_pkg::LD_D, soc_pkg::SD_AVAIL_REG, 64'd0, rdata, low);
        compare_value("available after new start", rdata, 64'd0);
        @(posedge CLOCK_50);
        sd_ready <= 1'b1;
        bus_access(1'b0, soc_pkg::LD_D, soc_pkg::SD_READY_REG, 64'd0, rdata, low);
        compare_value("sd ready high", rdata, 64'd1);
        @(posedge CLOCK_50);
        sd_ready <= 1'b0;
        bus_access(1'b0, soc_pkg::LD_D, soc_pkg::SD_READY_REG, 64'd0, rdata, low);
        compare_value("sd ready low", rdata, 64'd0);
        report_test("sd sector buffer", errs0);

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
soc_pkg.sv
data_ram.sv
key_irq_ctrl.sv
sd_sector_buffer.sv
soc_bus_bridge.sv
soc_bus_top.sv
soc_bus_assertions.sv
tb_soc_bus.sv

// File: Makefile
# Verilator build and run of tb_soc_bus

SRCS := $(shell grep -v '^+' sources.f)

run: obj_dir/Vtb_soc_bus
	./obj_dir/Vtb_soc_bus > sim.log; cat sim.log
	grep -q "Result: PASSED" sim.log

obj_dir/Vtb_soc_bus: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_soc_bus \
		-f sources.f -o Vtb_soc_bus

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
